/* all.f */
logic/osf_pkg.sv
logic/osf_config_regs.sv
logic/oversample_filter.sv
logic/osf_subsystem.sv
verif/tb_osf_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the oversample filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_osf_subsystem \
    -f all.f \
    -o sim_osf

./obj_dir/sim_osf 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi

echo "simulation passed"

/* verif/tb_osf_subsystem.sv */
module tb_osf_subsystem
    import osf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk_in = 1'b0;
    logic        rst_in;
    logic        sample_valid;
    osf_sample_t sample_in;
    osf_wr_t     wr;
    logic        out_valid;
    osf_sample_t sample_out;

    // Expected output driven beside each sample and delayed by the fixed latency
    logic        exp_in_valid;
    osf_sample_t exp_in_sample;
    logic        exp_valid_d1;
    logic        exp_valid_d2;
    logic        exp_valid_d3;
    osf_sample_t exp_sample_d1;
    osf_sample_t exp_sample_d2;
    osf_sample_t exp_sample_d3;
    logic        rst_prev = 1'b0;

    // Reference state per channel
    longint      model_sum [N_CHAN];
    int          model_count [N_CHAN];
    int          model_os [N_CHAN];
    int          sent_count [N_CHAN];
    int          out_count [N_CHAN];

    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = 32'ha6ce_bcbe;

    osf_subsystem i_osf_subsystem (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .wr           (wr),
        .out_valid    (out_valid),
        .sample_out   (sample_out)
    );

    // 50 MHz clock
    always #10 clk_in = ~clk_in;

    // --------------------------------------------------
    // Expected-output delay line and output tally
    // --------------------------------------------------

    always @(posedge clk_in) begin
        rst_prev <= rst_in;
        if (rst_in) begin
            exp_valid_d1 <= 1'b0;
            exp_valid_d2 <= 1'b0;
            exp_valid_d3 <= 1'b0;
            for (int c = 0; c < N_CHAN; c++) begin
                out_count[c] <= 0;
            end
        end else begin
            exp_valid_d1  <= exp_in_valid;
            exp_valid_d2  <= exp_valid_d1;
            exp_valid_d3  <= exp_valid_d2;
            exp_sample_d1 <= exp_in_sample;
            exp_sample_d2 <= exp_sample_d1;
            exp_sample_d3 <= exp_sample_d2;
            if (out_valid) begin
                out_count[sample_out.chan] <= out_count[sample_out.chan] + 1;
            end
        end
    end

    a_out_valid: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_valid == exp_valid_d3
    ) else begin
        $display("MISMATCH at %0t: out_valid got %0b expected %0b", $time,
                 $sampled(out_valid), $sampled(exp_valid_d3));
        error_count++;
    end

    a_out_chan: assert property (
        @(posedge clk_in) disable iff (rst_in)
        exp_valid_d3 |-> (sample_out.chan == exp_sample_d3.chan)
    ) else begin
        $display("MISMATCH at %0t: sample_out.chan got %0d expected %0d", $time,
                 $sampled(sample_out.chan), $sampled(exp_sample_d3.chan));
        error_count++;
    end

    a_out_data: assert property (
        @(posedge clk_in) disable iff (rst_in)
        exp_valid_d3 |-> (sample_out.data == exp_sample_d3.data)
    ) else begin
        $display("MISMATCH at %0t: sample_out.data got %0d expected %0d", $time,
                 $signed($sampled(sample_out.data)), $signed($sampled(exp_sample_d3.data)));
        error_count++;
    end

    // Nothing comes out once reset has been seen on an edge
    a_rst_quiet: assert property (
        @(posedge clk_in) rst_prev |-> !out_valid
    ) else begin
        $display("Error at %0t: out_valid went high while reset was held", $time);
        error_count++;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    // Galois LFSR on x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // One sample plus its model result on the same cycle
    task automatic send_sample(input logic [W_CHAN-1:0] chan,
                               input logic signed [W_DATA-1:0] data);
        longint avg;
        sent_count[chan]++;
        model_sum[chan] += data;
        model_count[chan]++;
        exp_in_valid = 1'b0;
        if (model_count[chan] >= (1 << model_os[chan])) begin
            // Floor division by 2^os
            avg = model_sum[chan] >>> model_os[chan];
            exp_in_valid = 1'b1;
            exp_in_sample.chan = chan;
            exp_in_sample.data = avg[W_DATA-1:0];
            model_sum[chan] = 0;
            model_count[chan] = 0;
        end
        sample_valid = 1'b1;
        sample_in.chan = chan;
        sample_in.data = data;
        @(negedge clk_in);
    endtask

    task automatic write_reg(input logic [W_WR_ADDR-1:0] addr, input int chan,
                             input int os, input logic en);
        sample_valid = 1'b0;
        exp_in_valid = 1'b0;
        wr.en   = en;
        wr.addr = addr;
        wr.chan = W_WR_CHAN'(chan);
        wr.data = W_WR_DATA'(os);
        if (en && addr == OS_ADDR) begin
            model_os[chan] = os;
        end
        @(negedge clk_in);
        wr = '0;
    endtask

    // Idle until the 3-cycle pipeline is empty
    task automatic drain();
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        sample_valid = 1'b0;
        exp_in_valid = 1'b0;
        while (quiet < 3 && waited < 50) begin
            @(negedge clk_in);
            waited++;
            quiet = (exp_valid_d1 || exp_valid_d2 || exp_valid_d3 || out_valid) ? 0 : quiet + 1;
        end
        if (quiet < 3) begin
            $display("Error at %0t: pipeline still busy after 50 idle cycles", $time);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        rst_in = 1'b1;
        sample_valid = 1'b0;
        exp_in_valid = 1'b0;
        wr = '0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_in);
        end
        for (int c = 0; c < N_CHAN; c++) begin
            model_sum[c] = 0;
            model_count[c] = 0;
            model_os[c] = 0;
            sent_count[c] = 0;
        end
        rst_in = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, error_count - errs_before);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int          errs;
        logic [31:0] ch;
        logic [31:0] d;
        rst_in = 1'b1;
        sample_valid = 1'b0;
        sample_in = '0;
        wr = '0;
        exp_in_valid = 1'b0;
        exp_in_sample = '0;
        apply_reset();

        // All os at zero after reset
        errs = error_count;
        for (int i = 0; i < 24; i++) begin
            ch = take_bits(W_CHAN);
            d  = take_bits(W_DATA);
            send_sample(ch[W_CHAN-1:0], d[W_DATA-1:0]);
        end
        drain();
        end_test("pass_through", errs);

        // Groups of 4 on channel 3 and 16 on channel 9
        errs = error_count;
        write_reg(OS_ADDR, 3, 2, 1'b1);
        write_reg(OS_ADDR, 9, 4, 1'b1);
        for (int i = 0; i < 32; i++) begin
            d = take_bits(W_DATA);
            send_sample(5'd9, d[W_DATA-1:0]);
            if (i % 2 == 0) begin
                d = take_bits(W_DATA);
                send_sample(5'd3, d[W_DATA-1:0]);
            end
        end
        drain();
        end_test("averaging", errs);

        // Random channels every cycle with repeats of the last one
        errs = error_count;
        apply_reset();
        for (int c = 0; c < N_CHAN; c++) begin
            write_reg(OS_ADDR, c, int'(take_bits(2)), 1'b1);
        end
        ch = '0;
        for (int i = 0; i < 400; i++) begin
            if (take_bits(2) != 0) begin
                ch = take_bits(W_CHAN);
            end
            d = take_bits(W_DATA);
            send_sample(ch[W_CHAN-1:0], d[W_DATA-1:0]);
        end
        drain();
        for (int c = 0; c < N_CHAN; c++) begin
            assert (out_count[c] == (sent_count[c] >> model_os[c])) else begin
                $display("MISMATCH at %0t: out_count[%0d] got %0d expected %0d", $time, c,
                         out_count[c], sent_count[c] >> model_os[c]);
                error_count++;
            end
        end
        end_test("interleave", errs);

        // Only OS_ADDR with en set reaches the register
        errs = error_count;
        write_reg(OS_ADDR, 5, 1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            send_sample(5'd5, 18'sd100 * i - 18'sd7);
        end
        write_reg(16'h0011, 5, 3, 1'b1);
        write_reg(16'h0000, 5, 3, 1'b1);
        write_reg(OS_ADDR, 5, 3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            send_sample(5'd5, -18'sd33 * i);
        end
        // Lowered group size lands mid-group
        write_reg(OS_ADDR, 5, 2, 1'b1);
        for (int i = 0; i < 9; i++) begin
            d = take_bits(W_DATA);
            send_sample(5'd5, d[W_DATA-1:0]);
        end
        drain();
        end_test("decode", errs);

        // Partial group on channel 7 is lost over reset
        errs = error_count;
        apply_reset();
        write_reg(OS_ADDR, 7, 3, 1'b1);
        for (int i = 0; i < 5; i++) begin
            send_sample(5'd7, 18'sd5000);
        end
        // Channel 2 passes straight through so an output is in flight at reset
        send_sample(5'd2, 18'sd77);
        apply_reset();
        write_reg(OS_ADDR, 7, 3, 1'b1);
        for (int i = 0; i < 8; i++) begin
            send_sample(5'd7, -18'sd3 - i);
        end
        drain();
        assert (out_count[7] == 1) else begin
            $display("MISMATCH at %0t: out_count[7] got %0d expected 1", $time, out_count[7]);
            error_count++;
        end
        end_test("reset_mid_group", errs);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* logic/osf_subsystem.sv */
module osf_subsystem
    import osf_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_in,

    // Sample stream in
    input  logic        sample_valid,
    input  osf_sample_t sample_in,

    // Configuration bus
    input  osf_wr_t     wr,

    // Averaged stream out
    output logic        out_valid,
    output osf_sample_t sample_out
);

    // Oversample lookup between filter and registers
    logic [W_CHAN-1:0] os_chan;
    logic [W_OS-1:0]   os_value;

    // --------------------------------------------------
    // Per-channel oversample setting
    // --------------------------------------------------

    osf_config_regs i_osf_config_regs (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .wr       (wr),
        .os_chan  (os_chan),
        .os_value (os_value)
    );

    // --------------------------------------------------
    // Averaging pipeline, 3 cycle latency
    // --------------------------------------------------

    oversample_filter i_oversample_filter (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .os_chan      (os_chan),
        .os_value     (os_value),
        .out_valid    (out_valid),
        .sample_out   (sample_out)
    );

endmodule

/* logic/oversample_filter.sv */
module oversample_filter
    import osf_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,

    // Input stream
    input  logic              sample_valid,
    input  osf_sample_t       sample_in,

    // Oversample lookup
    output logic [W_CHAN-1:0] os_chan,
    input  logic [W_OS-1:0]   os_value,

    // Averaged output
    output logic              out_valid,
    output osf_sample_t       sample_out
);

    // Running state of one channel
    typedef struct packed {
        logic signed [W_SUM-1:0] sum;
        logic [W_COUNT-1:0]      count;
    } acc_t;

    // Per-channel sums and counts
    acc_t acc_mem [N_CHAN];

    // Stage 1 registers
    logic        s1_valid;
    osf_sample_t s1_sample;
    acc_t        s1_acc;

    // Stage 2 registers
    logic              s2_valid;
    logic [W_CHAN-1:0] s2_chan;
    acc_t              s2_acc;
    logic [W_OS-1:0]   s2_os;

    // Combinational helpers
    acc_t                    fetch_acc;
    acc_t                    base_acc;
    acc_t                    wb_acc;
    logic                    wb_done;
    logic [W_COUNT-1:0]      wb_limit;
    logic signed [W_SUM-1:0] data_ext;
    logic signed [W_SUM-1:0] avg_sum;

    // --------------------------------------------------
    // Stage 3 writeback, from stage 2 registers
    // --------------------------------------------------

    // Group size is 2^os
    assign wb_limit = W_COUNT'(1) << s2_os;

    // At least, so a lowered os still closes the group
    assign wb_done  = s2_acc.count >= wb_limit;

    // Clear channel state on completion
    assign wb_acc   = wb_done ? '0 : s2_acc;

    // Divide by shifting, rounds toward minus infinity
    assign avg_sum  = $signed(s2_acc.sum) >>> s2_os;

    // --------------------------------------------------
    // Forwarding
    // --------------------------------------------------

    // Fetch for a new sample
    // The write landing on this same edge is not yet in memory
    always_comb begin
        if (s2_valid && (s2_chan == sample_in.chan)) begin
            fetch_acc = wb_acc;
        end else begin
            fetch_acc = acc_mem[sample_in.chan];
        end
    end

    // Back-to-back on one channel
    // Previous sample's result is still in stage 2
    always_comb begin
        if (s2_valid && (s2_chan == s1_sample.chan)) begin
            base_acc = wb_acc;
        end else begin
            base_acc = s1_acc;
        end
    end

    // Sign-extend to accumulator width
    assign data_ext = {{(W_SUM-W_DATA){s1_sample.data[W_DATA-1]}}, s1_sample.data};

    // Config lookup happens while the sample sits in stage 1
    assign os_chan = s1_sample.chan;

    // --------------------------------------------------
    // Pipeline
    // --------------------------------------------------

    // Payload registers, no reset
    always_ff @(posedge clk_in) begin
        // Stage 1: capture and fetch
        s1_sample <= sample_in;
        s1_acc    <= fetch_acc;

        // Stage 2: accumulate and count
        s2_chan         <= s1_sample.chan;
        s2_acc.sum      <= base_acc.sum + data_ext;
        s2_acc.count    <= base_acc.count + W_COUNT'(1);
        s2_os           <= os_value;

        // Stage 3: averaged result
        sample_out.chan <= s2_chan;
        sample_out.data <= avg_sum[W_DATA-1:0];
    end

    // Valids and channel state
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
            // Drop all partial groups
            for (int i = 0; i < N_CHAN; i++) begin
                acc_mem[i] <= '0;
            end
        end else begin
            s1_valid  <= sample_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid && wb_done;
            if (s2_valid) begin
                acc_mem[s2_chan] <= wb_acc;
            end
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Output only ever follows an accepted sample by three cycles
    a_out_latency: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_valid |-> $past(sample_valid, 3)
    ) else $error("oversample_filter: out_valid without sample three cycles back");

    // Count bounded by the largest group, 2^15
    a_count_max: assert property (
        @(posedge clk_in) disable iff (rst_in)
        s2_valid |-> (s2_acc.count <= (W_COUNT'(1) << ((1 << W_OS) - 1)))
    ) else $error("oversample_filter: count %0d on channel %0d", s2_acc.count, s2_chan);

endmodule

/* logic/osf_config_regs.sv */
module osf_config_regs
    import osf_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,

    // Configuration writes
    input  osf_wr_t           wr,

    // Lookup port for the filter
    input  logic [W_CHAN-1:0] os_chan,
    output logic [W_OS-1:0]   os_value
);

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------

    // Per-channel oversample exponent
    logic [W_OS-1:0]   os_mem [N_CHAN];

    logic              wr_hit;
    logic [W_CHAN-1:0] wr_idx;
    logic [W_OS-1:0]   wr_os;

    // Only the oversample address is live
    assign wr_hit = wr.en && (wr.addr == OS_ADDR);

    // Low bits of channel and data
    assign wr_idx = wr.chan[W_CHAN-1:0];
    assign wr_os  = wr.data[W_OS-1:0];

    // --------------------------------------------------
    // Register array
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            // Zero everywhere, i.e. pass-through
            for (int i = 0; i < N_CHAN; i++) begin
                os_mem[i] <= '0;
            end
        end else if (wr_hit) begin
            os_mem[wr_idx] <= wr_os;
        end
    end

    // Combinational read for stage 1 of the filter
    assign os_value = os_mem[os_chan];

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Decoded write must address an existing channel
    a_wr_chan_range: assert property (
        @(posedge clk_in) disable iff (rst_in)
        wr_hit |-> (wr.chan[W_WR_CHAN-1:W_CHAN] == '0)
    ) else $error("osf_config_regs: write to channel %0d out of range", wr.chan);

endmodule

/* logic/osf_pkg.sv */
package osf_pkg;

    // --------------------------------------------------
    // Channel and sample sizing
    // --------------------------------------------------

    // Channels in the multiplexed stream
    localparam int N_CHAN  = 32;
    localparam int W_CHAN  = 5;

    // Signed sample width
    localparam int W_DATA  = 18;

    // Oversample exponent, 0 to 15
    localparam int W_OS    = 4;

    // Counter holds 2^15 with room to spare
    localparam int W_COUNT = 17;

    // Sum of 2^15 full-scale samples
    localparam int W_SUM   = 34;

    // --------------------------------------------------
    // Write strobe bus
    // --------------------------------------------------

    localparam int W_WR_ADDR = 16;
    localparam int W_WR_CHAN = 16;
    localparam int W_WR_DATA = 48;

    // Oversample register select
    localparam logic [W_WR_ADDR-1:0] OS_ADDR = 16'h0010;

    // --------------------------------------------------
    // Shared types
    // --------------------------------------------------

    // One sample, input and output side alike
    typedef struct packed {
        logic [W_CHAN-1:0]        chan;
        logic signed [W_DATA-1:0] data;
    } osf_sample_t;

    // One write bus transaction
    typedef struct packed {
        logic                 en;
        logic [W_WR_ADDR-1:0] addr;
        logic [W_WR_CHAN-1:0] chan;
        logic [W_WR_DATA-1:0] data;
    } osf_wr_t;

endpackage
